/* dpp.f */
+incdir+logic
logic/dpp_state_pkg.sv
logic/dpp_table_pkg.sv
logic/philo.sv
logic/hunger_ager.sv
logic/fork_ledger.sv
logic/seat_granter.sv
logic/dpp_table.sv
sim/tb_clock_gen.sv
sim/dpp_table_tb.sv

/* Bender.yml */
package:
  name: dpp

sources:
  - include_dirs:
      - logic
    files:
      - logic/dpp_state_pkg.sv
      - logic/dpp_table_pkg.sv
      - logic/philo.sv
      - logic/hunger_ager.sv
      - logic/fork_ledger.sv
      - logic/seat_granter.sv
      - logic/dpp_table.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/tb_clock_gen.sv
      - sim/dpp_table_tb.sv

/* sim/dpp_table_tb.sv */
`include "dpp_defs.svh"

// directed tests for the philosopher table
// a negedge monitor rebuilds states, ages and fork use from the table rules
module dpp_table_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N            = `DPP_NUM_PHILO;
  localparam int W            = dpp_state_pkg::PHILO_STATE_W;
  localparam int A            = `DPP_AGE_WIDTH;
  localparam int EAT_LEN      = `DPP_EAT_TIME + 1;    // cycles spent eating
  localparam int THINK_LEN    = `DPP_THINK_TIME + 1;  // cycles spent thinking
  localparam int AGE_MAX      = (1 << A) - 1;
  localparam int RESET_CYCLES = 8;
  localparam int MEAL_PERIOD  = EAT_LEN + 1;  // meal plus the settle cycle
  localparam int FAIR_BOUND   = N * MEAL_PERIOD;  // longest allowed hungry run

  // random run lengths stay inside these
  localparam int GRANT_MIN = 150;
  localparam int GRANT_MAX = 250;
  localparam int FAIR_MIN  = 300;
  localparam int FAIR_MAX  = 450;
  localparam int DELAY_MIN = 20;
  localparam int DELAY_MAX = 80;

  localparam int RESET_PHASE_LEN = RESET_CYCLES + THINK_LEN + 4;
  localparam int MEAL_PHASE_LEN  = FAIR_BOUND + EAT_LEN + THINK_LEN + 2;
  localparam int TOTAL_LEN       = RESET_PHASE_LEN + GRANT_MAX + MEAL_PHASE_LEN + FAIR_MAX
                                 + DELAY_MAX + 2 + RESET_PHASE_LEN + FAIR_MAX;
  localparam int TIMEOUT_CYCLES  = TOTAL_LEN * 6 / 5;  // 20 percent headroom

  logic           clk;
  logic           reset;
  logic           reset_req;
  logic [N*W-1:0] philo_state;
  logic [N-1:0]   eat_grant;
  logic [N-1:0]   fork_busy;

  int check_count = 0;
  int error_count = 0;
  int cycle_count = 0;
  int grants_seen = 0;
  int meals[N];       // grants per seat since last clear
  int hungry_run[N];  // consecutive hungry cycles

  // monitor's view of the previous cycle
  bit           have_prev = 1'b0;
  logic [W-1:0] prev_st[N];
  int           prev_len[N];  // cycles already spent in prev_st
  int           prev_age[N];  // wait age derived from states
  logic [N-1:0] prev_grant;
  logic [N-1:0] prev_busy;
  logic [W-1:0] exp_st[N];    // states the rules give for this cycle

  int grant_len;
  int fair_len;
  int reset_delay;

  tb_clock_gen #(
    .PERIOD_NS    (40),
    .RESET_CYCLES (RESET_CYCLES)
  ) u_clk_gen (
    .reset_req (reset_req),
    .clk       (clk),
    .reset     (reset)
  );

  dpp_table u_dut (
    .clk         (clk),
    .reset       (reset),
    .philo_state (philo_state),
    .eat_grant   (eat_grant),
    .fork_busy   (fork_busy)
  );

  function automatic logic [W-1:0] seat_state(int i);
    return philo_state[i*W +: W];
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAILED %s: actual 0x%0h, expected 0x%0h", name, actual, expected);
    end
  endtask

  task automatic report_failure(input string what);
    error_count++;
    $display("%0t ns: %s", $time, what);
  endtask

  // state a seat must show this cycle given the last one
  function automatic logic [W-1:0] next_state(logic [W-1:0] st, int len, logic grant);
    case (st)
      dpp_state_pkg::thinking: return (len >= THINK_LEN) ? dpp_state_pkg::hungry : st;
      dpp_state_pkg::hungry:   return grant ? dpp_state_pkg::eating : st;
      dpp_state_pkg::eating:   return (len >= EAT_LEN) ? dpp_state_pkg::thinking : st;
      default:                 return dpp_state_pkg::thinking;
    endcase
  endfunction

  // largest age with both forks free wins and the first seat keeps a tie
  function automatic logic [N-1:0] oldest_free_seat();
    logic [N-1:0] win;
    int           best;
    win  = '0;
    best = 0;
    for (int s = 0; s < N; s++) begin
      if (prev_age[s] > best && !prev_busy[(s + N - 1) % N] && !prev_busy[s]) begin
        best   = prev_age[s];
        win    = '0;
        win[s] = 1'b1;
      end
    end
    return win;
  endfunction

  // a fork is in use while a neighbour eats and one cycle after
  function automatic logic [N-1:0] forks_in_use();
    logic [N-1:0] busy;
    int           r;
    for (int f = 0; f < N; f++) begin
      r       = (f + 1) % N;
      busy[f] = (exp_st[f] == dpp_state_pkg::eating) ||
                (exp_st[r] == dpp_state_pkg::eating) ||
                (prev_st[f] == dpp_state_pkg::eating) ||
                (prev_st[r] == dpp_state_pkg::eating);
    end
    return busy;
  endfunction

  task automatic check_reset_outputs(input string when);
    for (int i = 0; i < N; i++) begin
      check_value($sformatf("philo_state[%0d] %s", i, when), seat_state(i),
                  dpp_state_pkg::thinking);
    end
    check_value({"eat_grant ", when}, eat_grant, '0);
    check_value({"fork_busy ", when}, fork_busy, '0);
  endtask

  task automatic start_model();
    for (int i = 0; i < N; i++) begin
      prev_st[i]    = dpp_state_pkg::thinking;
      prev_len[i]   = 1;
      prev_age[i]   = 0;  // ages are clear out of reset
      hungry_run[i] = 0;
    end
    prev_grant = '0;
    prev_busy  = '0;
    have_prev  = 1'b1;
  endtask

  task automatic check_grant_rules();
    int seat;
    int ones;
    seat = 0;
    ones = 0;
    for (int i = 0; i < N; i++) begin
      if (eat_grant[i]) begin
        ones++;
        seat = i;
      end
    end
    if (ones != 1) report_failure($sformatf("eat_grant 0x%0h is not one-hot", eat_grant));
    if (prev_grant != '0) report_failure("eat grant in the cycle right after a grant");
    if (seat_state(seat) != dpp_state_pkg::hungry) begin
      report_failure($sformatf("seat %0d granted while not hungry", seat));
    end
    if (fork_busy[(seat + N - 1) % N] || fork_busy[seat]) begin
      report_failure($sformatf("seat %0d granted with a busy fork", seat));
    end
    grants_seen++;
    meals[seat]++;
  endtask

  task automatic check_cycle();
    logic [W-1:0] cur;
    logic [N-1:0] exp_grant;
    logic [N-1:0] exp_busy;
    int           age_now[N];
    for (int i = 0; i < N; i++) begin
      if (prev_st[i] == dpp_state_pkg::hungry) begin
        age_now[i] = (prev_age[i] < AGE_MAX) ? prev_age[i] + 1 : AGE_MAX;
      end else begin
        age_now[i] = 0;
      end
      exp_st[i] = next_state(prev_st[i], prev_len[i], prev_grant[i]);
      check_value($sformatf("philo_state[%0d]", i), seat_state(i), exp_st[i]);
    end
    exp_grant = (prev_grant != '0) ? '0 : oldest_free_seat();
    check_value("eat_grant", eat_grant, exp_grant);
    if (eat_grant != '0) check_grant_rules();
    exp_busy = forks_in_use();
    check_value("fork_busy", fork_busy, exp_busy);
    for (int i = 0; i < N; i++) begin
      cur = seat_state(i);
      if (cur == dpp_state_pkg::eating && seat_state((i + 1) % N) == dpp_state_pkg::eating) begin
        report_failure($sformatf("seats %0d and %0d eat at once", i, (i + 1) % N));
      end
      if (cur == dpp_state_pkg::hungry) begin
        hungry_run[i]++;
        if (hungry_run[i] == FAIR_BOUND + 1) begin
          report_failure($sformatf("seat %0d hungry for over %0d cycles", i, FAIR_BOUND));
        end
      end else begin
        hungry_run[i] = 0;
      end
      prev_len[i] = (exp_st[i] == prev_st[i]) ? prev_len[i] + 1 : 1;
      prev_st[i]  = exp_st[i];
      prev_age[i] = age_now[i];
    end
    prev_grant = exp_grant;
    prev_busy  = exp_busy;
  endtask

  // sample mid-cycle where outputs are settled
  always @(negedge clk) begin
    if (reset) begin
      check_reset_outputs("in reset");
      have_prev = 1'b0;
    end else if (!have_prev) begin
      check_reset_outputs("after reset");
      start_model();
    end else begin
      check_cycle();
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      error_count = error_count + 1;
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("checks: %0d, errors: %0d", check_count, error_count);
      $display("Test failures found");
      $finish;
    end
  end

  // wait for reset release and count cycles until each seat is hungry
  task automatic test_reset_state();
    int hungry_at[N];
    for (int i = 0; i < N; i++) hungry_at[i] = -1;
    @(negedge clk);
    if (!reset) report_failure("reset is not asserted at the start of the reset test");
    while (reset) @(negedge clk);
    for (int n = 0; n <= THINK_LEN + 2; n++) begin
      for (int i = 0; i < N; i++) begin
        if (hungry_at[i] < 0 && seat_state(i) == dpp_state_pkg::hungry) hungry_at[i] = n;
      end
      @(negedge clk);
    end
    for (int i = 0; i < N; i++) begin
      check_value($sformatf("hungry_delay[%0d]", i), hungry_at[i], THINK_LEN);
    end
  endtask

  // the monitor checks grant rules and this only checks that grants happen
  task automatic test_grant_rules(input int len);
    int start;
    @(posedge clk);
    start = grants_seen;
    repeat (len) @(posedge clk);
    if (grants_seen == start) report_failure($sformatf("no eat grant in %0d cycles", len));
  endtask

  // follow one granted seat through eating, thinking and back to hungry
  task automatic test_meal_timing();
    int seat;
    seat = -1;
    while (seat < 0) begin
      @(negedge clk);
      for (int i = 0; i < N; i++) begin
        if (eat_grant[i]) seat = i;
      end
    end
    repeat (EAT_LEN) begin
      @(negedge clk);
      check_value($sformatf("philo_state[%0d]", seat), seat_state(seat), dpp_state_pkg::eating);
    end
    repeat (THINK_LEN) begin
      @(negedge clk);
      check_value($sformatf("philo_state[%0d]", seat), seat_state(seat),
                  dpp_state_pkg::thinking);
    end
    @(negedge clk);
    check_value($sformatf("philo_state[%0d]", seat), seat_state(seat), dpp_state_pkg::hungry);
  endtask

  // every seat eats during a long run; hungry bound watched by the monitor
  task automatic test_fairness(input int len);
    @(posedge clk);
    for (int i = 0; i < N; i++) meals[i] = 0;
    repeat (len) @(posedge clk);
    for (int i = 0; i < N; i++) begin
      if (meals[i] == 0) report_failure($sformatf("seat %0d never ate in %0d cycles", i, len));
    end
  endtask

  task automatic test_mid_reset(input int delay);
    repeat (delay) @(posedge clk);
    reset_req <= 1'b1;
    @(posedge clk);
    reset_req <= 1'b0;  // clock gen has taken the request at this edge
    test_reset_state();
  endtask

  initial begin
    reset_req = 1'b0;
    void'($urandom(46));
    grant_len   = $urandom_range(GRANT_MAX, GRANT_MIN);
    fair_len    = $urandom_range(FAIR_MAX, FAIR_MIN);
    reset_delay = $urandom_range(DELAY_MAX, DELAY_MIN);
    test_reset_state();
    test_grant_rules(grant_len);
    test_meal_timing();
    test_fairness(fair_len);
    test_mid_reset(reset_delay);
    test_fairness(fair_len);  // table recovers after the reset
    @(posedge clk);
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* sim/tb_clock_gen.sv */
// free-running clock, reset held for a fixed count of edges
// at start-up and again whenever reset_req is seen high
module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 8
) (
  input  logic reset_req,  // one-cycle request from the testbench
  output logic clk,
  output logic reset
);
  timeunit 1ns;
  timeprecision 1ps;

  int hold;  // reset edges still to go

  initial begin
    clk   = 1'b0;
    reset = 1'b1;
    hold  = RESET_CYCLES;
  end

  always #(PERIOD_NS / 2) clk = ~clk;

  always @(posedge clk) begin
    if (reset_req) begin
      reset <= 1'b1;
      hold  <= RESET_CYCLES;
    end else if (hold > 0) begin
      hold <= hold - 1;
      if (hold == 1) begin
        reset <= 1'b0;  // dropped after the last reset edge
      end
    end
  end

endmodule

/* logic/dpp_table.sv */
`include "dpp_defs.svh"

// table top: ring of philosophers plus ager, ledger and granter
module dpp_table (
  input  logic                                       clk,
  input  logic                                       reset,
  output logic [`DPP_NUM_PHILO*dpp_state_pkg::PHILO_STATE_W-1:0] philo_state,
  output logic [`DPP_NUM_PHILO-1:0]                  eat_grant,
  output logic [`DPP_NUM_PHILO-1:0]                  fork_busy
);

  localparam int N = `DPP_NUM_PHILO;
  localparam int A = `DPP_AGE_WIDTH;
  localparam int W = dpp_state_pkg::PHILO_STATE_W;

  logic [N*A-1:0] wait_age;  // ager to granter

  // the ring; seat i gets bit i of the grant
  for (genvar i = 0; i < N; i++) begin : g_seat
    philo #(
      .EAT_TIME   (`DPP_EAT_TIME),
      .THINK_TIME (`DPP_THINK_TIME)
    ) u_philo (
      .clk     (clk),
      .reset   (reset),
      .eat_sig (eat_grant[i]),
      .state   (philo_state[i*W +: W])
    );
  end

  // how long each hungry seat has waited
  hunger_ager u_hunger_ager (
    .clk         (clk),
    .reset       (reset),
    .philo_state (philo_state),
    .wait_age    (wait_age)
  );

  // who holds which fork
  fork_ledger u_fork_ledger (
    .clk         (clk),
    .reset       (reset),
    .philo_state (philo_state),
    .eat_grant   (eat_grant),
    .fork_busy   (fork_busy)
  );

  // oldest seat with both forks free gets to eat
  seat_granter u_seat_granter (
    .clk       (clk),
    .reset     (reset),
    .wait_age  (wait_age),
    .fork_busy (fork_busy),
    .eat_grant (eat_grant)
  );

endmodule

/* logic/seat_granter.sv */
`include "dpp_defs.svh"

// picks the longest-waiting seat whose two forks are free
// one-hot eat pulse, then one quiet cycle so the ledger catches up
module seat_granter (
  input  logic                                     clk,
  input  logic                                     reset,
  input  logic [`DPP_NUM_PHILO*`DPP_AGE_WIDTH-1:0] wait_age,
  input  logic [`DPP_NUM_PHILO-1:0]                fork_busy,
  output logic [`DPP_NUM_PHILO-1:0]                eat_grant
);

  localparam int N = `DPP_NUM_PHILO;
  localparam int A = `DPP_AGE_WIDTH;

  typedef enum logic {
    grant_idle,    // free to grant
    grant_settle   // grant just went out, ledger not updated yet
  } grant_state_e;

  grant_state_e   gstate;
  logic [N-1:0]   eligible;
  logic [N-1:0]   pick;      // one-hot winner
  logic [A-1:0]   best_age;
  logic           found;

  // seat s eats with fork s-1 on its left and fork s on its right
  for (genvar s = 0; s < N; s++) begin : g_elig
    localparam int LEFT_FORK  = (s + N - 1) % N;
    localparam int RIGHT_FORK = s;

    assign eligible[s] = (wait_age[s*A +: A] != '0) &&
                         !fork_busy[LEFT_FORK] &&
                         !fork_busy[RIGHT_FORK];
  end

  // oldest eligible seat wins
  // strict compare so the lowest index keeps a tie
  always_comb begin
    pick     = '0;
    best_age = '0;
    found    = 1'b0;
    for (int s = 0; s < N; s++) begin
      if (eligible[s] && (!found || (wait_age[s*A +: A] > best_age))) begin
        pick     = '0;
        pick[s]  = 1'b1;
        best_age = wait_age[s*A +: A];
        found    = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      gstate    <= grant_idle;
      eat_grant <= '0;
    end else begin
      case (gstate)
        grant_idle: begin
          if (found) begin
            eat_grant <= pick;          // single-cycle pulse
            gstate    <= grant_settle;
          end else begin
            eat_grant <= '0;
          end
        end
        grant_settle: begin
          // forks of the last winner show busy from the next cycle
          eat_grant <= '0;
          gstate    <= grant_idle;
        end
        default: begin
          eat_grant <= '0;
          gstate    <= grant_idle;
        end
      endcase
    end
  end

endmodule

/* logic/fork_ledger.sv */
`include "dpp_defs.svh"

// owner table for the forks
// grant claims both forks of a seat, thinking owner gives them back
module fork_ledger (
  input  logic                                       clk,
  input  logic                                       reset,
  input  logic [`DPP_NUM_PHILO*dpp_state_pkg::PHILO_STATE_W-1:0] philo_state,
  input  logic [`DPP_NUM_PHILO-1:0]                  eat_grant,
  output logic [`DPP_NUM_PHILO-1:0]                  fork_busy
);

  localparam int N = `DPP_NUM_PHILO;
  localparam int W = dpp_state_pkg::PHILO_STATE_W;

  // fork f lies between seat f (left) and seat f+1 mod n (right)
  for (genvar f = 0; f < N; f++) begin : g_fork
    localparam int LEFT_SEAT  = f;
    localparam int RIGHT_SEAT = (f + 1) % N;

    dpp_table_pkg::fork_owner_e owner;

    logic left_take;    // seat f was granted, it wants this as its right fork
    logic right_take;   // seat f+1 was granted, this is its left fork
    logic left_done;    // left seat back to thinking
    logic right_done;
    logic release_now;

    assign left_take  = eat_grant[LEFT_SEAT];
    assign right_take = eat_grant[RIGHT_SEAT];

    assign left_done  = (philo_state[LEFT_SEAT*W +: W] == dpp_state_pkg::thinking);
    assign right_done = (philo_state[RIGHT_SEAT*W +: W] == dpp_state_pkg::thinking);

    // release only by whoever actually holds it
    assign release_now =
      ((owner == dpp_table_pkg::fork_left_seat) && left_done) ||
      ((owner == dpp_table_pkg::fork_right_seat) && right_done);

    always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
        owner <= dpp_table_pkg::fork_free;
      end else if (left_take) begin
        owner <= dpp_table_pkg::fork_left_seat;
      end else if (right_take) begin
        owner <= dpp_table_pkg::fork_right_seat;
      end else if (release_now) begin
        owner <= dpp_table_pkg::fork_free;  // visible the cycle after thinking seen
      end
    end

    assign fork_busy[f] = (owner != dpp_table_pkg::fork_free);
  end

endmodule

/* logic/hunger_ager.sv */
`include "dpp_defs.svh"

// counts how long each seat has been hungry
// age lags the state by one cycle; zero means not hungry
module hunger_ager (
  input  logic                                       clk,
  input  logic                                       reset,
  input  logic [`DPP_NUM_PHILO*dpp_state_pkg::PHILO_STATE_W-1:0] philo_state,
  output logic [`DPP_NUM_PHILO*`DPP_AGE_WIDTH-1:0]   wait_age
);

  localparam int N = `DPP_NUM_PHILO;
  localparam int A = `DPP_AGE_WIDTH;
  localparam int W = dpp_state_pkg::PHILO_STATE_W;

  localparam logic [A-1:0] AGE_MAX = {A{1'b1}};  // saturation point

  for (genvar s = 0; s < N; s++) begin : g_seat
    logic [A-1:0] age_q;
    logic         is_hungry;
    logic         at_max;

    assign is_hungry = (philo_state[s*W +: W] == dpp_state_pkg::hungry);
    assign at_max    = (age_q == AGE_MAX);

    always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
        age_q <= '0;
      end else if (is_hungry) begin
        if (!at_max) begin
          age_q <= age_q + 1'b1;  // first hungry cycle gives 1
        end
      end else begin
        age_q <= '0;  // left hungry, clear
      end
    end

    assign wait_age[s*A +: A] = age_q;
  end

endmodule

/* logic/philo.sv */
// one philosopher; thinks, gets hungry, eats when told, repeats
module philo #(
  parameter int EAT_TIME   = 2,
  parameter int THINK_TIME = 5
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        eat_sig,  // one-cycle strobe from the granter
  output dpp_state_pkg::philo_state_e state
);

  // timer must hold the larger reload value
  localparam int MAX_TIME = (EAT_TIME > THINK_TIME) ? EAT_TIME : THINK_TIME;
  localparam int TIMER_W  = (MAX_TIME > 0) ? $clog2(MAX_TIME + 1) : 1;

  logic [TIMER_W-1:0] timer;  // counts down to zero, then the phase ends
  logic               expired;

  assign expired = (timer == '0);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      timer <= TIMER_W'(THINK_TIME);
      state <= dpp_state_pkg::thinking;
    end else begin
      case (state)
        dpp_state_pkg::thinking: begin
          if (expired) begin
            state <= dpp_state_pkg::hungry;  // timer parks at zero
          end else begin
            timer <= timer - 1'b1;
          end
        end
        dpp_state_pkg::hungry: begin
          // wait here as long as it takes
          if (eat_sig) begin
            timer <= TIMER_W'(EAT_TIME);
            state <= dpp_state_pkg::eating;
          end
        end
        dpp_state_pkg::eating: begin
          if (expired) begin
            timer <= TIMER_W'(THINK_TIME);  // reload for next thinking phase
            state <= dpp_state_pkg::thinking;
          end else begin
            timer <= timer - 1'b1;
          end
        end
        default: begin
          // unused code 3, recover to a clean thinking phase
          timer <= TIMER_W'(THINK_TIME);
          state <= dpp_state_pkg::thinking;
        end
      endcase
    end
  end

endmodule

/* logic/dpp_table_pkg.sv */
package dpp_table_pkg;

  localparam int FORK_OWNER_W = 2;

  // owner relative to the fork index
  // fork i sits between seat i (left) and seat i+1 (right)
  typedef enum logic [FORK_OWNER_W-1:0] {
    fork_free       = 2'd0,
    fork_left_seat  = 2'd1,  // held by seat i
    fork_right_seat = 2'd2   // held by seat i+1 mod n
  } fork_owner_e;

endpackage

/* logic/dpp_state_pkg.sv */
package dpp_state_pkg;

  localparam int PHILO_STATE_W = 2;  // bits per seat on the state bus

  // fixed encodings with hungry at zero
  typedef enum logic [PHILO_STATE_W-1:0] {
    hungry   = 2'd0,
    thinking = 2'd1,  // bit 0 high only while thinking
    eating   = 2'd2
  } philo_state_e;

endpackage

/* logic/dpp_defs.svh */
`ifndef DPP_DEFS_SVH
`define DPP_DEFS_SVH

// seats around the table, one fork between each pair of neighbours
`define DPP_NUM_PHILO 5

// timer reload values; a phase lasts the reload value plus one cycle
`define DPP_EAT_TIME 2
`define DPP_THINK_TIME 5

// hungry wait counters, saturating
`define DPP_AGE_WIDTH 8

`endif
